// File: logic/evict_cfg.svh
`ifndef EVICT_CFG_SVH
`define EVICT_CFG_SVH

// Eviction queue geometry.
`define EVICT_SLOTS 4
`define EVICT_IDX_W 2

// A 32-byte line moves as four 64-bit beats.
`define LINE_BEATS 4
`define XLEN 64

// Physical address and the byte offset inside one line.
`define PADDR_W 32
`define LINE_OFS_W 5

`endif

// File: logic/evict_pkg.sv
`include "evict_cfg.svh"

package evict_pkg;

    // Physical address with the line offset stripped off.
    typedef logic [`PADDR_W-`LINE_OFS_W-1:0] blk_addr_t;

    // Beat 0 sits at the lowest address of the line.
    typedef logic [`LINE_BEATS-1:0][`XLEN-1:0] line_t;

    // Coherence state kept with a victim line and handed back on a snoop.
    typedef struct packed {
        logic dirty;
        logic shared;
    } dir_state_t;

endpackage

// File: logic/slot_select.sv
`include "evict_cfg.svh"

module slot_select #(
    parameter type payload_t = logic
) (
    input  logic [`EVICT_SLOTS-1:0]  req,
    input  payload_t                 payloads [`EVICT_SLOTS],
    output logic                     any,
    output logic [`EVICT_IDX_W-1:0]  sel_idx,
    output payload_t                 sel_payload
);

    // Scan from the top down so the lowest set request is the one that sticks.
    always_comb begin
        any = |req;
        sel_idx = '0;
        sel_payload = payloads[0];
        for (int i = `EVICT_SLOTS - 1; i >= 0; i--) begin
            if (req[i]) begin
                sel_idx = `EVICT_IDX_W'(i);
                sel_payload = payloads[i];
            end
        end
    end

endmodule

// File: logic/wb_burst_master.sv
`include "evict_cfg.svh"

module wb_burst_master (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       wb_valid,
    input  evict_pkg::blk_addr_t       wb_addr,
    input  evict_pkg::line_t           wb_data,
    output logic                       wb_ready,
    output logic                       wb_done,

    output logic                       aw_valid,
    input  logic                       aw_ready,
    output logic [`PADDR_W-1:0]        aw_addr,
    output logic [7:0]                 aw_len,
    output logic [2:0]                 aw_size,
    output logic [1:0]                 aw_burst,

    output logic                       w_valid,
    input  logic                       w_ready,
    output logic [`XLEN-1:0]           w_data,
    output logic [`XLEN/8-1:0]         w_strb,
    output logic                       w_last,

    input  logic                       b_valid,
    output logic                       b_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_WRITE,
        ST_RESP
    } wb_state_t;

    wb_state_t                        state;
    evict_pkg::blk_addr_t             addr_q;
    evict_pkg::line_t                 line_q;
    logic [$clog2(`LINE_BEATS)-1:0]   beat_q;

    assign wb_ready = (state == ST_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            beat_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wb_valid) begin
                        state <= ST_ADDR;
                        beat_q <= '0;
                    end
                end
                ST_ADDR: begin
                    if (aw_ready) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (w_ready) begin
                        if (w_last) begin
                            state <= ST_RESP;
                        end else begin
                            beat_q <= beat_q + 1'b1;
                        end
                    end
                end
                ST_RESP: begin
                    if (b_valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // The line is captured once and held for the whole burst.
    always_ff @(posedge clk) begin
        if (wb_valid && wb_ready) begin
            addr_q <= wb_addr;
            line_q <= wb_data;
        end
    end

    assign aw_valid = (state == ST_ADDR);
    assign aw_addr  = {addr_q, {`LINE_OFS_W{1'b0}}};
    assign aw_len   = 8'(`LINE_BEATS - 1);
    assign aw_size  = 3'($clog2(`XLEN / 8));
    assign aw_burst = 2'b01; // INCR.

    assign w_valid = (state == ST_WRITE);
    assign w_data  = line_q[beat_q];
    assign w_strb  = '1;
    assign w_last  = (beat_q == $clog2(`LINE_BEATS)'(`LINE_BEATS - 1));

    assign b_ready = 1'b1;
    assign wb_done = (state == ST_RESP) && b_valid;

endmodule

// File: logic/evict_queue.sv
`include "evict_cfg.svh"

module evict_queue (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       alloc_en,
    input  logic [`PADDR_W-1:0]        alloc_addr,
    output logic [`EVICT_IDX_W-1:0]    idx,
    output logic                       whit,
    output logic                       full,

    input  logic                       refill_en,
    input  logic [`EVICT_IDX_W-1:0]    refill_idx,
    input  logic                       refill_valid,
    input  evict_pkg::blk_addr_t       refill_addr,
    input  evict_pkg::line_t           refill_data,
    input  evict_pkg::dir_state_t      refill_state,

    input  logic                       snoop_en,
    input  logic                       snoop_clean,
    input  logic [`PADDR_W-1:0]        snoop_addr,
    output logic                       snoop_hit,
    output evict_pkg::line_t           snoop_data,
    output evict_pkg::dir_state_t      snoop_state,

    output logic                       wb_valid,
    output evict_pkg::blk_addr_t       wb_addr,
    output evict_pkg::line_t           wb_data,
    input  logic                       wb_ready,
    input  logic                       wb_done
);

    logic [`EVICT_SLOTS-1:0]    occupied, filled, prior, has_data, inflight;
    logic [`EVICT_SLOTS-1:0]    occupied_n, filled_n, prior_n, has_data_n, inflight_n;

    evict_pkg::blk_addr_t       slot_addr  [`EVICT_SLOTS];
    evict_pkg::line_t           slot_data  [`EVICT_SLOTS];
    evict_pkg::dir_state_t      slot_state [`EVICT_SLOTS];

    evict_pkg::blk_addr_t       look_blk, snoop_blk;
    logic [`EVICT_SLOTS-1:0]    whit_vec, snoop_vec, drainable, prior_drain;
    logic [`EVICT_SLOTS-1:0]    alloc_req, drain_req;
    logic                       alloc_any, alloc_hit, drain_any;
    logic [`EVICT_IDX_W-1:0]    alloc_idx, drain_idx, snoop_sel_idx, snoop_idx;
    logic                       snoop_any, enqueue_hit, snoop_release;
    evict_pkg::line_t           snoop_sel_data;
    evict_pkg::dir_state_t      snoop_sel_state;

    // A snoop borrows the conflict port in the cycle it arrives.
    assign look_blk  = snoop_en ? snoop_addr[`PADDR_W-1:`LINE_OFS_W]
                                : alloc_addr[`PADDR_W-1:`LINE_OFS_W];
    assign snoop_blk = snoop_addr[`PADDR_W-1:`LINE_OFS_W];

    always_comb begin
        for (int i = 0; i < `EVICT_SLOTS; i++) begin
            whit_vec[i]  = occupied[i] & filled[i] & has_data[i] & (slot_addr[i] == look_blk);
            snoop_vec[i] = occupied[i] & filled[i] & has_data[i] & (slot_addr[i] == snoop_blk);
            drainable[i] = occupied[i] & filled[i] & has_data[i] & ~inflight[i];
        end
    end

    // One selector serves both the conflict index and the free slot.
    assign alloc_hit = |whit_vec;
    assign alloc_req = alloc_hit ? whit_vec : ~occupied;

    slot_select #(
        .payload_t (evict_pkg::blk_addr_t)
    ) u_sel_alloc (
        .req         (alloc_req),
        .payloads    (slot_addr),
        .any         (alloc_any),
        .sel_idx     (alloc_idx),
        .sel_payload ()
    );

    // Marked lines drain ahead of the rest.
    assign prior_drain = drainable & prior;
    assign drain_req   = (|prior_drain) ? prior_drain : drainable;

    slot_select #(
        .payload_t (evict_pkg::blk_addr_t)
    ) u_sel_drain (
        .req         (drain_req),
        .payloads    (slot_addr),
        .any         (drain_any),
        .sel_idx     (drain_idx),
        .sel_payload (wb_addr)
    );

    assign wb_valid = drain_any;
    assign wb_data  = slot_data[drain_idx];

    slot_select #(
        .payload_t (evict_pkg::line_t)
    ) u_sel_snoop_data (
        .req         (snoop_vec),
        .payloads    (slot_data),
        .any         (snoop_any),
        .sel_idx     (snoop_sel_idx),
        .sel_payload (snoop_sel_data)
    );

    slot_select #(
        .payload_t (evict_pkg::dir_state_t)
    ) u_sel_snoop_state (
        .req         (snoop_vec),
        .payloads    (slot_state),
        .any         (),
        .sel_idx     (),
        .sel_payload (snoop_sel_state)
    );

    // A refill landing this cycle answers the snoop before it reaches the slot.
    assign enqueue_hit   = refill_en & refill_valid & (refill_addr == snoop_blk);
    assign snoop_idx     = enqueue_hit ? refill_idx : snoop_sel_idx;
    assign snoop_release = snoop_en & snoop_clean & (snoop_any | enqueue_hit);

    always_comb begin
        occupied_n = occupied;
        filled_n   = filled;
        prior_n    = prior;
        has_data_n = has_data;
        inflight_n = inflight;

        if (wb_valid && wb_ready) begin
            inflight_n[drain_idx] = 1'b1;
        end

        // The burst is done, so whatever slot is still tied to it goes free.
        if (wb_done) begin
            occupied_n = occupied_n & ~inflight;
            filled_n   = filled_n & ~inflight;
            prior_n    = prior_n & ~inflight;
            inflight_n = inflight_n & ~inflight;
        end

        occupied_n = occupied_n & ~(filled & ~has_data); // Nothing to write back.
        filled_n   = filled_n & ~(filled & ~has_data);

        if (alloc_en) begin
            if (alloc_hit) begin
                prior_n[alloc_idx] = 1'b1;
            end else if (alloc_any) begin
                occupied_n[alloc_idx] = 1'b1;
                filled_n[alloc_idx]   = 1'b0;
                prior_n[alloc_idx]    = 1'b0;
                has_data_n[alloc_idx] = 1'b0;
            end
        end

        if (refill_en) begin
            filled_n[refill_idx]   = 1'b1;
            has_data_n[refill_idx] = refill_valid;
        end

        if (snoop_release) begin
            occupied_n[snoop_idx] = 1'b0;
            filled_n[snoop_idx]   = 1'b0;
            prior_n[snoop_idx]    = 1'b0;
            inflight_n[snoop_idx] = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occupied  <= '0;
            filled    <= '0;
            prior     <= '0;
            has_data  <= '0;
            inflight  <= '0;
            full      <= 1'b0;
            whit      <= 1'b0;
            idx       <= '0;
            snoop_hit <= 1'b0;
        end else begin
            occupied <= occupied_n;
            filled   <= filled_n;
            prior    <= prior_n;
            has_data <= has_data_n;
            inflight <= inflight_n;
            full     <= &occupied_n;
            if (alloc_en) begin
                whit <= alloc_hit;
                idx  <= alloc_idx;
            end
            if (snoop_en) begin
                snoop_hit <= snoop_any | enqueue_hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_en) begin
            slot_addr[refill_idx]  <= refill_addr;
            slot_data[refill_idx]  <= refill_data;
            slot_state[refill_idx] <= refill_state;
        end
        if (snoop_en) begin
            snoop_data  <= enqueue_hit ? refill_data : snoop_sel_data;
            snoop_state <= enqueue_hit ? refill_state : snoop_sel_state;
        end
    end

endmodule

// File: logic/evict_top.sv
`include "evict_cfg.svh"

module evict_top (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       alloc_en,
    input  logic [`PADDR_W-1:0]        alloc_addr,
    output logic [`EVICT_IDX_W-1:0]    idx,
    output logic                       whit,
    output logic                       full,

    input  logic                       refill_en,
    input  logic [`EVICT_IDX_W-1:0]    refill_idx,
    input  logic                       refill_valid,
    input  evict_pkg::blk_addr_t       refill_addr,
    input  evict_pkg::line_t           refill_data,
    input  evict_pkg::dir_state_t      refill_state,

    input  logic                       snoop_en,
    input  logic                       snoop_clean,
    input  logic [`PADDR_W-1:0]        snoop_addr,
    output logic                       snoop_hit,
    output evict_pkg::line_t           snoop_data,
    output evict_pkg::dir_state_t      snoop_state,

    output logic                       aw_valid,
    input  logic                       aw_ready,
    output logic [`PADDR_W-1:0]        aw_addr,
    output logic [7:0]                 aw_len,
    output logic [2:0]                 aw_size,
    output logic [1:0]                 aw_burst,

    output logic                       w_valid,
    input  logic                       w_ready,
    output logic [`XLEN-1:0]           w_data,
    output logic [`XLEN/8-1:0]         w_strb,
    output logic                       w_last,

    input  logic                       b_valid,
    output logic                       b_ready
);

    logic                    wb_valid;
    logic                    wb_ready;
    logic                    wb_done;
    evict_pkg::blk_addr_t    wb_addr;
    evict_pkg::line_t        wb_data;

    evict_queue u_queue (
        .clk          (clk),
        .rst          (rst),
        .alloc_en     (alloc_en),
        .alloc_addr   (alloc_addr),
        .idx          (idx),
        .whit         (whit),
        .full         (full),
        .refill_en    (refill_en),
        .refill_idx   (refill_idx),
        .refill_valid (refill_valid),
        .refill_addr  (refill_addr),
        .refill_data  (refill_data),
        .refill_state (refill_state),
        .snoop_en     (snoop_en),
        .snoop_clean  (snoop_clean),
        .snoop_addr   (snoop_addr),
        .snoop_hit    (snoop_hit),
        .snoop_data   (snoop_data),
        .snoop_state  (snoop_state),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .wb_ready     (wb_ready),
        .wb_done      (wb_done)
    );

    wb_burst_master u_wb (
        .clk      (clk),
        .rst      (rst),
        .wb_valid (wb_valid),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .wb_ready (wb_ready),
        .wb_done  (wb_done),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_addr  (aw_addr),
        .aw_len   (aw_len),
        .aw_size  (aw_size),
        .aw_burst (aw_burst),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .w_strb   (w_strb),
        .w_last   (w_last),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

endmodule

// File: verification/evict_top_sva.sv
`include "evict_cfg.svh"

module evict_top_sva (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       aw_valid,
    input  logic                       aw_ready,
    input  logic [`PADDR_W-1:0]        aw_addr,
    input  logic [7:0]                 aw_len,
    input  logic [2:0]                 aw_size,
    input  logic [1:0]                 aw_burst,
    input  logic                       w_valid,
    input  logic                       w_ready,
    input  logic [`XLEN-1:0]           w_data,
    input  logic                       w_last,
    input  logic                       alloc_en,
    input  logic                       whit,
    input  logic                       full
);

    int unsigned sva_errors = 0;
    logic [$clog2(`LINE_BEATS)-1:0] beat_cnt;

    // Beat position inside the current write burst.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (w_valid && w_ready) begin
            beat_cnt <= w_last ? '0 : beat_cnt + 1'b1;
        end
    end

    aw_stable: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable({aw_addr, aw_len, aw_size, aw_burst}))
        else begin
            $error("AW valid or payload changed while the address channel was stalled");
            sva_errors++;
        end

    w_stable: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable({w_data, w_last}))
        else begin
            $error("W valid or payload changed while the write channel was stalled");
            sva_errors++;
        end

    w_last_beat: assert property (@(posedge clk) disable iff (rst)
        w_valid && w_ready |-> (w_last == (beat_cnt == `LINE_BEATS - 1)))
        else begin
            $error("w_last does not line up with the final beat of the line");
            sva_errors++;
        end

    // Full only rises when an alloc has just taken the last free slot.
    full_on_alloc: assert property (@(posedge clk) disable iff (rst)
        $rose(full) |-> $past(alloc_en) && !whit)
        else begin
            $error("full rose without an alloc taking a free slot");
            sva_errors++;
        end

endmodule

// File: verification/evict_top_tb.sv
`include "evict_cfg.svh"

module evict_top_tb;

    localparam int NUM_TESTS = 6;
    localparam int LINES_PER_TEST = 4;
    localparam int BURST_WORST = 100; // Padded cycle count for one burst under random back-pressure.
    localparam int WATCHDOG_CYCLES = 16 + NUM_TESTS * LINES_PER_TEST * BURST_WORST;
    localparam evict_pkg::blk_addr_t BLK_BASE = 27'h0123400;

    logic                       clk;
    logic                       rst;
    logic                       alloc_en;
    logic [`PADDR_W-1:0]        alloc_addr;
    logic [`EVICT_IDX_W-1:0]    idx;
    logic                       whit;
    logic                       full;
    logic                       refill_en;
    logic [`EVICT_IDX_W-1:0]    refill_idx;
    logic                       refill_valid;
    evict_pkg::blk_addr_t       refill_addr;
    evict_pkg::line_t           refill_data;
    evict_pkg::dir_state_t      refill_state;
    logic                       snoop_en;
    logic                       snoop_clean;
    logic [`PADDR_W-1:0]        snoop_addr;
    logic                       snoop_hit;
    evict_pkg::line_t           snoop_data;
    evict_pkg::dir_state_t      snoop_state;
    logic                       aw_valid;
    logic                       aw_ready;
    logic [`PADDR_W-1:0]        aw_addr;
    logic [7:0]                 aw_len;
    logic [2:0]                 aw_size;
    logic [1:0]                 aw_burst;
    logic                       w_valid;
    logic                       w_ready;
    logic [`XLEN-1:0]           w_data;
    logic [`XLEN/8-1:0]         w_strb;
    logic                       w_last;
    logic                       b_valid;
    logic                       b_ready;

    integer                     seed = 32'h7d2dec56;
    int                         errors = 0;
    logic                       hold_aw;
    logic                       hold_b;
    logic                       b_pend;
    int                         beat_n;
    evict_pkg::line_t           cur_line;
    logic [44:0]                aw_log [$];     // {addr, len, size, burst} per accepted AW.
    logic [44:0]                burst_aw [$];
    evict_pkg::line_t           burst_line [$];
    evict_pkg::blk_addr_t       pend [$];       // Lines that still owe one write-back.
    evict_pkg::blk_addr_t       drained [$];
    event                       burst_seen;

    evict_top u_dut (.*);

    bind evict_top evict_top_sva u_sva (
        .clk      (clk),
        .rst      (rst),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_addr  (aw_addr),
        .aw_len   (aw_len),
        .aw_size  (aw_size),
        .aw_burst (aw_burst),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .w_last   (w_last),
        .alloc_en (alloc_en),
        .whit     (whit),
        .full     (full)
    );

    // Each beat repeats the block address with the beat number appended.
    function automatic evict_pkg::line_t ref_line(input evict_pkg::blk_addr_t blk);
        evict_pkg::line_t line;
        logic [86:0] rep;
        for (int b = 0; b < `LINE_BEATS; b++) begin
            rep = {3{blk, 2'(b)}};
            line[b] = rep[`XLEN-1:0];
        end
        return line;
    endfunction

    function automatic evict_pkg::blk_addr_t blk_of(input int n);
        return evict_pkg::blk_addr_t'(BLK_BASE + n);
    endfunction

    function automatic logic [`PADDR_W-1:0] phys_addr(input evict_pkg::blk_addr_t blk,
                                                      input logic [`LINE_OFS_W-1:0] ofs);
        return {blk, ofs};
    endfunction

    task automatic check_idx(input string name, input logic [`EVICT_IDX_W-1:0] exp,
                             input logic [`EVICT_IDX_W-1:0] act);
        if (act !== exp) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_line(input string name, input evict_pkg::line_t exp,
                              input evict_pkg::line_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_state(input string name, input evict_pkg::dir_state_t exp,
                               input evict_pkg::dir_state_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_blk(input string name, input evict_pkg::blk_addr_t exp,
                             input evict_pkg::blk_addr_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_axi(input string name, input logic [`PADDR_W-1:0] exp,
                             input logic [`PADDR_W-1:0] act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic request_slot(input string name, input logic [`PADDR_W-1:0] addr,
                                input logic [`EVICT_IDX_W-1:0] exp_idx, input logic exp_whit);
        alloc_en = 1'b1;
        alloc_addr = addr;
        tick();
        alloc_en = 1'b0;
        check_idx(name, exp_idx, idx);
        check_bit(name, exp_whit, whit);
    endtask

    task automatic refill_slot(input logic [`EVICT_IDX_W-1:0] slot,
                               input evict_pkg::blk_addr_t blk, input logic valid,
                               input evict_pkg::dir_state_t state, input logic snoop_too);
        refill_en = 1'b1;
        refill_idx = slot;
        refill_valid = valid;
        refill_addr = blk;
        refill_data = ref_line(blk);
        refill_state = state;
        snoop_en = snoop_too; // Same-cycle snoop hits the refill bypass.
        snoop_addr = phys_addr(blk, '0);
        if (valid) begin
            pend.push_back(blk);
        end
        tick();
        refill_en = 1'b0;
        snoop_en = 1'b0;
    endtask

    task automatic snoop_line(input string name, input logic [`PADDR_W-1:0] addr,
                              input logic clean, input logic exp_hit,
                              input evict_pkg::dir_state_t exp_state);
        snoop_en = 1'b1;
        snoop_clean = clean;
        snoop_addr = addr;
        tick();
        snoop_en = 1'b0;
        snoop_clean = 1'b0;
        check_bit(name, exp_hit, snoop_hit);
        if (exp_hit) begin
            check_line(name, ref_line(addr[`PADDR_W-1:`LINE_OFS_W]), snoop_data);
            check_state(name, exp_state, snoop_state);
        end
    endtask

    // Returns once every expected line is written and its response is taken.
    task automatic wait_drained();
        while (pend.size() != 0 || b_pend) begin
            tick();
        end
        tick();
        tick();
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // The AXI memory model samples handshakes at the falling edge, where the bus has settled.
    initial begin : axi_slave
        logic [31:0] rnd;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (b_valid) begin
                    check_bit("b_ready", 1'b1, b_ready);
                end
                if (b_valid && b_ready) begin
                    b_pend = 1'b0;
                end
                if (aw_valid && aw_ready) begin
                    aw_log.push_back({aw_addr, aw_len, aw_size, aw_burst});
                end
                if (w_valid && w_ready) begin
                    if (w_strb !== '1) begin
                        $display("Fail w_strb: expected %h, actual %h",
                                 {(`XLEN/8){1'b1}}, w_strb);
                        errors++;
                    end
                    if (beat_n < `LINE_BEATS) begin
                        cur_line[beat_n] = w_data;
                    end
                    beat_n++;
                    if (w_last) begin
                        if (aw_log.size() == 0) begin
                            $display("A write burst ended without any accepted address");
                            errors++;
                        end else begin
                            burst_aw.push_back(aw_log.pop_front());
                            burst_line.push_back(cur_line);
                            -> burst_seen;
                        end
                        beat_n = 0;
                        b_pend = 1'b1;
                    end
                end
            end
            @(posedge clk);
            #1;
            rnd = $random(seed);
            aw_ready = rnd[0] & ~hold_aw;
            w_ready = rnd[1];
            b_valid = b_pend & ~hold_b;
        end
    end

    initial begin : compare_bursts
        logic [44:0] aw_rec;
        evict_pkg::line_t got;
        evict_pkg::blk_addr_t blk;
        int hit_at;
        forever begin
            @(burst_seen);
            while (burst_aw.size() != 0) begin
                aw_rec = burst_aw.pop_front();
                got = burst_line.pop_front();
                blk = aw_rec[44:18];
                check_axi("aw_addr", phys_addr(blk, '0), aw_rec[44:13]);
                check_axi("aw_len", `LINE_BEATS - 1, aw_rec[12:5]);
                check_axi("aw_size", 3, aw_rec[4:2]);
                check_axi("aw_burst", 1, aw_rec[1:0]);
                check_line("burst data", ref_line(blk), got);
                hit_at = -1;
                foreach (pend[i]) begin
                    if (hit_at < 0 && pend[i] == blk) begin
                        hit_at = i;
                    end
                end
                if (hit_at < 0) begin
                    $display("Burst to block %h was not expected, nothing was pending", blk);
                    errors++;
                end else begin
                    pend.delete(hit_at);
                end
                drained.push_back(blk);
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run stopped making progress",
                 WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : stimulus
        int mark;
        int total;
        rst = 1'b1;
        alloc_en = 1'b0;
        alloc_addr = '0;
        refill_en = 1'b0;
        refill_idx = '0;
        refill_valid = 1'b0;
        refill_addr = '0;
        refill_data = '0;
        refill_state = '0;
        snoop_en = 1'b0;
        snoop_clean = 1'b0;
        snoop_addr = '0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        hold_aw = 1'b1;
        hold_b = 1'b0;
        b_pend = 1'b0;
        beat_n = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        tick();
        check_bit("reset aw_valid", 1'b0, aw_valid);
        check_bit("reset w_valid", 1'b0, w_valid);
        check_bit("reset whit", 1'b0, whit);
        check_bit("reset full", 1'b0, full);
        check_bit("reset snoop_hit", 1'b0, snoop_hit);

        // Allocation order with the address channel held off.
        for (int i = 0; i < 4; i++) begin
            request_slot("alloc order", phys_addr(blk_of(i), 5'h08), `EVICT_IDX_W'(i), 1'b0);
            check_bit("full after alloc", i == 3, full);
        end

        // Write-back bursts for all four slots.
        for (int i = 0; i < 4; i++) begin
            refill_slot(`EVICT_IDX_W'(i), blk_of(i), 1'b1, evict_pkg::dir_state_t'(2'(i)), 1'b0);
        end
        hold_aw = 1'b0;
        wait_drained();
        check_bit("full after drain", 1'b0, full);
        request_slot("slot reuse", phys_addr(blk_of(16), '0), 0, 1'b0);

        // A data-less refill frees the slot without touching the bus.
        refill_slot(0, blk_of(16), 1'b0, '0, 1'b0);
        tick();
        request_slot("data-less reuse", phys_addr(blk_of(17), '0), 0, 1'b0);
        refill_slot(0, blk_of(17), 1'b0, '0, 1'b0);
        tick();
        tick();
        check_bit("full after data-less", 1'b0, full);

        // Write conflict marks the third line, which then overtakes the second.
        hold_aw = 1'b1;
        mark = drained.size();
        for (int i = 0; i < 3; i++) begin
            request_slot("conflict setup", phys_addr(blk_of(32 + i), '0), `EVICT_IDX_W'(i), 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            refill_slot(`EVICT_IDX_W'(i), blk_of(32 + i), 1'b1, 2'b10, 1'b0);
        end
        request_slot("write conflict", phys_addr(blk_of(34), 5'h10), 2, 1'b1);
        hold_aw = 1'b0;
        wait_drained();
        if (drained.size() < mark + 3) begin
            $display("Fewer bursts than expected were seen in the priority test");
            errors++;
        end else begin
            check_blk("drain in flight", blk_of(32), drained[mark]);
            check_blk("priority drain", blk_of(34), drained[mark + 1]);
            check_blk("drain last", blk_of(33), drained[mark + 2]);
        end

        // Snoop lookups, a miss, and the refill bypass.
        hold_aw = 1'b1;
        request_slot("snoop setup", phys_addr(blk_of(48), '0), 0, 1'b0);
        request_slot("snoop setup", phys_addr(blk_of(49), '0), 1, 1'b0);
        refill_slot(0, blk_of(48), 1'b1, 2'b10, 1'b0);
        refill_slot(1, blk_of(49), 1'b1, 2'b11, 1'b0);
        snoop_line("snoop waiting line", phys_addr(blk_of(49), 5'h18), 1'b0, 1'b1, 2'b11);
        snoop_line("snoop miss", phys_addr(blk_of(60), '0), 1'b0, 1'b0, '0);
        request_slot("snoop setup", phys_addr(blk_of(50), '0), 2, 1'b0);
        refill_slot(2, blk_of(50), 1'b1, 2'b01, 1'b1);
        check_bit("snoop bypass", 1'b1, snoop_hit);
        check_line("snoop bypass", ref_line(blk_of(50)), snoop_data);
        check_state("snoop bypass", 2'b01, snoop_state);
        hold_aw = 1'b0;
        wait_drained();

        // Clean snoop while the first burst waits on its response.
        hold_b = 1'b1;
        request_slot("clean setup", phys_addr(blk_of(64), '0), 0, 1'b0);
        request_slot("clean setup", phys_addr(blk_of(65), '0), 1, 1'b0);
        refill_slot(0, blk_of(64), 1'b1, 2'b10, 1'b0);
        refill_slot(1, blk_of(65), 1'b1, 2'b10, 1'b0);
        snoop_line("snoop clean", phys_addr(blk_of(65), '0), 1'b1, 1'b1, 2'b10);
        pend.pop_back(); // The cleaned line is never written back.
        request_slot("reuse after clean", phys_addr(blk_of(66), '0), 1, 1'b0);
        hold_b = 1'b0;
        wait_drained();
        refill_slot(1, blk_of(66), 1'b0, '0, 1'b0);
        tick();
        tick();
        check_bit("full at end", 1'b0, full);

        repeat (8) tick();
        check_bit("no stray bursts", 1'b1, burst_aw.size() == 0 && pend.size() == 0);
        total = errors + u_dut.u_sva.sva_errors;
        $display("Errors: %0d from checks, %0d from assertions", errors, u_dut.u_sva.sva_errors);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: evict_top.f
+incdir+logic
logic/evict_pkg.sv
logic/slot_select.sv
logic/wb_burst_master.sv
logic/evict_queue.sv
logic/evict_top.sv
verification/evict_top_sva.sv
verification/evict_top_tb.sv

// File: Bender.yml
package:
  name: evict_top

sources:
  - include_dirs:
      - logic
    files:
      - logic/evict_pkg.sv
      - logic/slot_select.sv
      - logic/wb_burst_master.sv
      - logic/evict_queue.sv
      - logic/evict_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/evict_top_sva.sv
      - verification/evict_top_tb.sv
